// File: Bender.yml
package:
  name: cpu16

sources:
  - hw/cpu_isa_pkg.sv
  - hw/cpu_pipe_pkg.sv
  - hw/register_file.sv
  - hw/fetch_stage.sv
  - hw/decode_stage.sv
  - hw/execute_stage.sv
  - hw/memory_stage.sv
  - hw/writeback_stage.sv
  - hw/cpu.sv
  - target: simulation
    files:
      - tb/cpu_tb.sv

// File: hw/cpu.sv
`default_nettype none

module cpu import cpu_isa_pkg::*, cpu_pipe_pkg::*; (
	input wire clk,
	input wire arst_n,
	output word_t imem_addr,
	input wire word_t imem_data,
	output logic hlt,
	output word_t pc,
	output wb_trace_t wb_trace
);
	// Pipeline registers
	fd_t fd;
	de_t de;
	em_t em;
	mw_t mw;
	// Branch path back to fetch
	logic branch_taken;
	word_t branch_target;
	// nzv from execute
	flags_t flags;
	// Register file ports
	reg_idx_t rs_idx, rt_idx, wr_idx;
	word_t rs_data, rt_data, wr_data;
	logic wr_en;

	// Fetch address is the PC
	assign imem_addr = pc;

	fetch_stage fetch_stage (
		.clk(clk), .arst_n(arst_n),
		.halt(hlt),
		.branch_taken(branch_taken), .branch_target(branch_target),
		.imem_addr(pc), .imem_data(imem_data),
		.fd(fd)
	);

	// Also resolves branches and halt
	decode_stage decode_stage (
		.clk(clk), .arst_n(arst_n),
		.fd(fd), .flags(flags),
		.rs_idx(rs_idx), .rt_idx(rt_idx),
		.rs_data(rs_data), .rt_data(rt_data),
		.branch_taken(branch_taken), .branch_target(branch_target),
		.halt(hlt),
		.de(de)
	);

	execute_stage execute_stage (
		.clk(clk), .arst_n(arst_n),
		.de(de), .flags(flags), .em(em)
	);

	memory_stage memory_stage (
		.clk(clk), .arst_n(arst_n),
		.em(em), .mw(mw)
	);

	writeback_stage writeback_stage (
		.clk(clk), .arst_n(arst_n),
		.mw(mw),
		.wr_en(wr_en), .wr_idx(wr_idx), .wr_data(wr_data),
		.wb_trace(wb_trace)
	);

	// Read by decode, written by writeback
	register_file register_file (
		.clk(clk), .arst_n(arst_n),
		.rs_idx(rs_idx), .rt_idx(rt_idx),
		.rs_data(rs_data), .rt_data(rt_data),
		.wr_en(wr_en), .wr_idx(wr_idx), .wr_data(wr_data)
	);
endmodule

`default_nettype wire

// File: hw/cpu_isa_pkg.sv
`default_nettype none

package cpu_isa_pkg;

	// Data and address word
	typedef logic [15:0] word_t;
	// Register index
	typedef logic [3:0] reg_idx_t;

	// Opcode in bits 15..12, unlisted codes act as nop
	typedef enum logic [3:0] {
		OP_ADD = 4'd0,
		OP_SUB = 4'd1,
		OP_XOR = 4'd2,
		OP_SLL = 4'd3,
		OP_SRA = 4'd4,
		OP_LLI = 4'd5,
		OP_LW  = 4'd8,
		OP_SW  = 4'd9,
		OP_B   = 4'd12,
		OP_HLT = 4'd15
	} opcode_e;

	// ALU operation, PASSB forwards operand b
	typedef enum logic [2:0] {
		ALU_ADD   = 3'd0,
		ALU_SUB   = 3'd1,
		ALU_XOR   = 3'd2,
		ALU_SLL   = 3'd3,
		ALU_SRA   = 3'd4,
		ALU_PASSB = 3'd5
	} alu_op_e;

	// Branch condition in bits 11..9, codes 4..6 never taken
	typedef enum logic [2:0] {
		COND_EQ = 3'd0,
		COND_NE = 3'd1,
		COND_LT = 3'd2,
		COND_GE = 3'd3,
		COND_AL = 3'd7
	} cond_e;

	typedef struct packed {
		logic n;
		logic z;
		logic v;
	} flags_t;

	// Data memory depth in words
	localparam int DMEM_WORDS = 256;

endpackage

`default_nettype wire

// File: hw/cpu_pipe_pkg.sv
`default_nettype none

package cpu_pipe_pkg;

	import cpu_isa_pkg::*;

	// Fetch to decode
	typedef struct packed {
		logic  valid;
		word_t instr;
		word_t pc_plus2;
	} fd_t;

	// Decode to execute
	typedef struct packed {
		logic     valid;
		reg_idx_t rd;
		word_t    a;
		word_t    b;
		word_t    store_data;
		alu_op_e  alu_op;
		logic     set_flags;
		logic     mem_read;
		logic     mem_write;
		logic     reg_write;
	} de_t;

	// Execute to memory
	typedef struct packed {
		logic     valid;
		reg_idx_t rd;
		word_t    alu_res;
		word_t    store_data;
		logic     mem_read;
		logic     mem_write;
		logic     reg_write;
	} em_t;

	// Memory to writeback
	typedef struct packed {
		logic     valid;
		reg_idx_t rd;
		word_t    alu_res;
		word_t    load_data;
		// Load data instead of ALU result
		logic     load_sel;
		logic     reg_write;
	} mw_t;

	// One register write as seen from outside
	typedef struct packed {
		logic     valid;
		reg_idx_t rd;
		word_t    data;
	} wb_trace_t;

endpackage

`default_nettype wire

// File: hw/decode_stage.sv
`default_nettype none

module decode_stage import cpu_isa_pkg::*, cpu_pipe_pkg::*; (
	input wire clk,
	input wire arst_n,
	input wire fd_t fd,
	input wire flags_t flags,
	output reg_idx_t rs_idx,
	output reg_idx_t rt_idx,
	input wire word_t rs_data,
	input wire word_t rt_data,
	output logic branch_taken,
	output word_t branch_target,
	output logic halt,
	output de_t de
);
	opcode_e op;
	cond_e cond;
	logic live;
	logic cond_true;
	logic halt_q;
	word_t imm8_sext;
	word_t imm4_x2;
	word_t shamt;
	de_t de_d;

	// Fields
	assign op = opcode_e'(fd.instr[15:12]);
	assign cond = cond_e'(fd.instr[11:9]);
	// Nothing issues once halted
	assign live = fd.valid & ~halt_q;

	// Base register in 7..4, SW data register in 11..8
	assign rs_idx = fd.instr[7:4];
	assign rt_idx = (op == OP_SW) ? fd.instr[11:8] : fd.instr[3:0];

	// Immediates
	assign imm8_sext = {{8{fd.instr[7]}}, fd.instr[7:0]};
	assign imm4_x2 = {{11{fd.instr[3]}}, fd.instr[3:0], 1'b0};
	assign shamt = {12'd0, fd.instr[3:0]};

	// Branch offset counts words
	assign branch_target = fd.pc_plus2 + {{6{fd.instr[8]}}, fd.instr[8:0], 1'b0};

	// Condition against flags from execute
	always_comb begin
		case (cond)
			COND_EQ: cond_true = flags.z;
			COND_NE: cond_true = ~flags.z;
			COND_LT: cond_true = flags.n ^ flags.v;
			COND_GE: cond_true = ~(flags.n ^ flags.v);
			COND_AL: cond_true = 1'b1;
			default: cond_true = 1'b0;
		endcase
	end

	assign branch_taken = live & (op == OP_B) & cond_true;
	assign halt = halt_q;

	// Control generation
	always_comb begin
		de_d = '0;
		de_d.valid = live;
		de_d.rd = fd.instr[11:8];
		de_d.a = rs_data;
		de_d.b = rt_data;
		de_d.store_data = rt_data;
		case (op)
			OP_ADD, OP_SUB, OP_XOR: begin
				de_d.alu_op = (op == OP_ADD) ? ALU_ADD : (op == OP_SUB) ? ALU_SUB : ALU_XOR;
				de_d.set_flags = 1'b1;
				de_d.reg_write = 1'b1;
			end
			// Shift amount is the 4-bit immediate
			OP_SLL, OP_SRA: begin
				de_d.alu_op = (op == OP_SLL) ? ALU_SLL : ALU_SRA;
				de_d.b = shamt;
				de_d.reg_write = 1'b1;
			end
			OP_LLI: begin
				de_d.alu_op = ALU_PASSB;
				de_d.b = imm8_sext;
				de_d.reg_write = 1'b1;
			end
			// Address is base plus scaled offset
			OP_LW: begin
				de_d.b = imm4_x2;
				de_d.mem_read = 1'b1;
				de_d.reg_write = 1'b1;
			end
			OP_SW: begin
				de_d.b = imm4_x2;
				de_d.mem_write = 1'b1;
			end
			default: begin
			end
		endcase
	end

	// Sticky halt, cleared only by reset
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			halt_q <= 1'b0;
		end else if (live && op == OP_HLT) begin
			halt_q <= 1'b1;
		end
	end

	// Decode/execute register
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			de <= '0;
		end else begin
			de <= de_d;
		end
	end
endmodule

`default_nettype wire

// File: hw/execute_stage.sv
`default_nettype none

module execute_stage import cpu_isa_pkg::*, cpu_pipe_pkg::*; (
	input wire clk,
	input wire arst_n,
	input wire de_t de,
	output flags_t flags,
	output em_t em
);
	word_t res;
	logic ovf;

	// ALU, shifts use the low four bits of b
	always_comb begin
		case (de.alu_op)
			ALU_ADD: res = de.a + de.b;
			ALU_SUB: res = de.a - de.b;
			ALU_XOR: res = de.a ^ de.b;
			ALU_SLL: res = de.a << de.b[3:0];
			ALU_SRA: res = $signed(de.a) >>> de.b[3:0];
			default: res = de.b;
		endcase
	end

	// Signed overflow, none for xor
	always_comb begin
		case (de.alu_op)
			ALU_ADD: ovf = (de.a[15] == de.b[15]) && (res[15] != de.a[15]);
			ALU_SUB: ovf = (de.a[15] != de.b[15]) && (res[15] != de.a[15]);
			default: ovf = 1'b0;
		endcase
	end

	// Flag register, read by decode for branches
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			flags <= '0;
		end else if (de.valid && de.set_flags) begin
			flags <= {res[15], res == '0, ovf};
		end
	end

	// Execute/memory register
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			em <= '0;
		end else begin
			em.valid      <= de.valid;
			em.rd         <= de.rd;
			em.alu_res    <= res;
			em.store_data <= de.store_data;
			em.mem_read   <= de.mem_read;
			em.mem_write  <= de.mem_write;
			em.reg_write  <= de.reg_write;
		end
	end
endmodule

`default_nettype wire

// File: hw/fetch_stage.sv
`default_nettype none

module fetch_stage import cpu_isa_pkg::*, cpu_pipe_pkg::*; (
	input wire clk,
	input wire arst_n,
	input wire halt,
	input wire branch_taken,
	input wire word_t branch_target,
	output word_t imem_addr,
	input wire word_t imem_data,
	output fd_t fd
);
	word_t pc_q;
	word_t pc_plus2;

	assign pc_plus2 = pc_q + 16'd2;
	// Instruction port answers in the same cycle
	assign imem_addr = pc_q;

	// PC: step, redirect, or freeze once halted
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			pc_q <= '0;
		end else if (!halt) begin
			pc_q <= branch_taken ? branch_target : pc_plus2;
		end
	end

	// Fetch/decode register
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			fd <= '0;
		end else begin
			// Squash slot behind a taken branch, and everything after halt
			fd.valid    <= ~halt & ~branch_taken;
			fd.instr    <= imem_data;
			fd.pc_plus2 <= pc_plus2;
		end
	end
endmodule

`default_nettype wire

// File: hw/memory_stage.sv
`default_nettype none

module memory_stage import cpu_isa_pkg::*, cpu_pipe_pkg::*; (
	input wire clk,
	input wire arst_n,
	input wire em_t em,
	output mw_t mw
);
	localparam int IDX_W = $clog2(DMEM_WORDS);

	word_t dmem [DMEM_WORDS];
	logic [IDX_W-1:0] idx;

	// Word addressed, bit 0 ignored
	assign idx = em.alu_res[IDX_W:1];

	// Store at the edge
	always_ff @(posedge clk) begin
		if (em.valid && em.mem_write) begin
			dmem[idx] <= em.store_data;
		end
	end

	// Memory/writeback register, load read is combinational
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			mw <= '0;
		end else begin
			mw.valid     <= em.valid;
			mw.rd        <= em.rd;
			mw.alu_res   <= em.alu_res;
			mw.load_data <= dmem[idx];
			mw.load_sel  <= em.mem_read;
			mw.reg_write <= em.reg_write;
		end
	end
endmodule

`default_nettype wire

// File: hw/register_file.sv
`default_nettype none

module register_file import cpu_isa_pkg::*; (
	input wire clk,
	input wire arst_n,
	input wire reg_idx_t rs_idx,
	input wire reg_idx_t rt_idx,
	output word_t rs_data,
	output word_t rt_data,
	input wire wr_en,
	input wire reg_idx_t wr_idx,
	input wire word_t wr_data
);
	word_t regs [16];

	// One read port, r0 is zero, same-cycle write bypassed
	function automatic word_t read_port(reg_idx_t idx);
		if (idx == '0) begin
			return '0;
		end else if (wr_en && wr_idx == idx) begin
			return wr_data;
		end
		return regs[idx];
	endfunction

	always_comb begin
		rs_data = read_port(rs_idx);
		rt_data = read_port(rt_idx);
	end

	// r0 never stored
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			regs <= '{default: '0};
		end else if (wr_en && wr_idx != '0) begin
			regs[wr_idx] <= wr_data;
		end
	end
endmodule

`default_nettype wire

// File: hw/writeback_stage.sv
`default_nettype none

module writeback_stage import cpu_isa_pkg::*, cpu_pipe_pkg::*; (
	input wire clk,
	input wire arst_n,
	input wire mw_t mw,
	output logic wr_en,
	output reg_idx_t wr_idx,
	output word_t wr_data,
	output wb_trace_t wb_trace
);
	// Register file write
	assign wr_en = mw.valid & mw.reg_write;
	assign wr_idx = mw.rd;
	assign wr_data = mw.load_sel ? mw.load_data : mw.alu_res;

	// Trace loads on the same edge as the register file, r0 not reported
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			wb_trace <= '0;
		end else begin
			wb_trace.valid <= wr_en && (wr_idx != '0);
			wb_trace.rd    <= wr_idx;
			wb_trace.data  <= wr_data;
		end
	end
endmodule

`default_nettype wire

// File: tb/cpu_tb.sv
`default_nettype none

module cpu_tb import cpu_isa_pkg::*, cpu_pipe_pkg::*; ();

	localparam int MAX_WAIT = 200;
	localparam int PROG_WORDS = 32;
	// Unused opcode 6 writes nothing and sets no flags
	localparam word_t NOP = 16'h6000;

	logic clk;
	logic arst_n;
	word_t imem_addr;
	word_t imem_data;
	logic hlt;
	word_t pc;
	wb_trace_t wb_trace;

	// Program words and the ordered register writes it must produce
	word_t prog [$];
	wb_trace_t exp_writes [$];
	word_t exp_final_pc;
	integer seed;

	cpu dut (
		.clk(clk), .arst_n(arst_n),
		.imem_addr(imem_addr), .imem_data(imem_data),
		.hlt(hlt), .pc(pc), .wb_trace(wb_trace)
	);

	always #20 clk = ~clk;

	// Instruction port answers the current PC
	always begin
		@(posedge clk);
		#2;
		imem_data = fetch_word(imem_addr);
	end

	function automatic word_t fetch_word(word_t addr);
		int idx;
		idx = int'(addr[15:1]);
		// Past the table reads as zero
		if (idx < prog.size()) begin
			return prog[idx];
		end
		return '0;
	endfunction

	function automatic word_t alu_instr(opcode_e op, reg_idx_t rd, reg_idx_t rs, reg_idx_t rt);
		return {op, rd, rs, rt};
	endfunction

	function automatic word_t load_imm(reg_idx_t rd, logic [7:0] imm);
		return {OP_LLI, rd, imm};
	endfunction

	// r is the load target or the store source
	function automatic word_t mem_instr(opcode_e op, reg_idx_t r, reg_idx_t base, logic [3:0] off);
		return {op, r, base, off};
	endfunction

	// Word offset from the next PC
	function automatic word_t branch_instr(cond_e cond, logic [8:0] off);
		return {OP_B, cond, off};
	endfunction

	function automatic word_t sext8(logic [7:0] x);
		return {{8{x[7]}}, x};
	endfunction

	task automatic expect_write(reg_idx_t rd, word_t data);
		wb_trace_t t;
		t.valid = 1'b1;
		t.rd = rd;
		t.data = data;
		exp_writes.push_back(t);
	endtask

	task automatic report_failure(string msg);
		$display("%s", msg);
		$display("=== FAIL ===");
		$fatal(1, "simulation stopped at first error");
	endtask

	task automatic check_trace(wb_trace_t got, wb_trace_t exp, int num);
		if (got !== exp) begin
			report_failure($sformatf(
				"Error at time %0t: write %0d is rd=%0d data=%h, expected rd=%0d data=%h",
				$time, num, got.rd, got.data, exp.rd, exp.data));
		end
	endtask

	task automatic check_word(word_t got, word_t exp, string what);
		if (got !== exp) begin
			report_failure($sformatf("Error at time %0t: %s is %h, expected %h",
				$time, what, got, exp));
		end
	endtask

	// Next valid trace entry sampled at the falling edge while hlt stays low
	task automatic wait_for_trace(output wb_trace_t got);
		int n;
		n = 0;
		do begin
			@(negedge clk);
			n++;
			check_word(word_t'(hlt), '0, "hlt before the last write");
		end while (wb_trace.valid !== 1'b1 && n < MAX_WAIT);
		if (wb_trace.valid !== 1'b1) begin
			report_failure("Timeout: no register write seen within 200 cycles");
		end else begin
			got = wb_trace;
		end
	endtask

	// No writes allowed while waiting
	task automatic wait_for_halt();
		int n;
		n = 0;
		do begin
			@(negedge clk);
			n++;
			if (wb_trace.valid !== 1'b0) begin
				report_failure("Unexpected register write while waiting for halt");
			end
		end while (hlt !== 1'b1 && n < MAX_WAIT);
		if (hlt !== 1'b1) begin
			report_failure("Timeout: hlt did not rise within 200 cycles");
		end
	endtask

	task automatic build_program();
		integer r;
		logic [7:0] ia, ib, ic;
		logic [3:0] sh1, sh2;
		word_t v1, v2, v3, v_min;
		r = $random(seed);
		ia = r[7:0];
		r = $random(seed);
		ib = r[7:0];
		r = $random(seed);
		ic = r[7:0];
		r = $random(seed);
		sh1 = r[3:0];
		r = $random(seed);
		sh2 = r[3:0];
		v1 = sext8(ia);
		v2 = sext8(ib);
		v3 = sext8(ic);
		v_min = 16'd1 << 15;
		// Operands with three slots before first use
		prog.push_back(load_imm(1, ia));
		prog.push_back(load_imm(2, ib));
		prog.push_back(load_imm(3, ic));
		prog.push_back(load_imm(13, 8'd1));
		// Base r0 makes the address twice the offset
		prog.push_back(mem_instr(OP_SW, 1, 0, 4'd3));
		prog.push_back(alu_instr(OP_ADD, 4, 1, 2));
		prog.push_back(alu_instr(OP_SUB, 5, 1, 2));
		prog.push_back(alu_instr(OP_XOR, 6, 1, 3));
		prog.push_back(alu_instr(OP_SLL, 7, 1, sh1));
		prog.push_back(alu_instr(OP_SRA, 8, 2, sh2));
		prog.push_back(alu_instr(OP_SLL, 14, 13, 4'd15));
		// Neighbouring word then both read back
		prog.push_back(mem_instr(OP_SW, 2, 0, 4'd4));
		prog.push_back(mem_instr(OP_LW, 9, 0, 4'd4));
		prog.push_back(mem_instr(OP_LW, 10, 0, 4'd3));
		// Equal operands give z
		prog.push_back(alu_instr(OP_SUB, 11, 1, 1));
		prog.push_back(NOP);
		prog.push_back(NOP);
		prog.push_back(branch_instr(COND_EQ, 9'd2));
		// Squashed slot and skipped word
		prog.push_back(load_imm(12, 8'h7e));
		prog.push_back(load_imm(12, 8'h55));
		// z still set and NE falls through
		prog.push_back(branch_instr(COND_NE, 9'd5));
		// 0x8000 minus 1 overflows with n clear and v set
		prog.push_back(alu_instr(OP_SUB, 15, 14, 13));
		prog.push_back(NOP);
		prog.push_back(NOP);
		prog.push_back(branch_instr(COND_LT, 9'd2));
		prog.push_back(load_imm(12, 8'h33));
		prog.push_back(load_imm(12, 8'h44));
		// PC takes one more step on the edge that raises hlt
		exp_final_pc = word_t'(2 * prog.size() + 4);
		prog.push_back(16'hf000);
		// Fetched behind HLT and never written back
		prog.push_back(load_imm(12, 8'h11));
		prog.push_back(load_imm(12, 8'h22));
		// Writes in program order
		expect_write(1, v1);
		expect_write(2, v2);
		expect_write(3, v3);
		expect_write(13, 16'd1);
		expect_write(4, v1 + v2);
		expect_write(5, v1 - v2);
		expect_write(6, v1 ^ v3);
		expect_write(7, v1 << sh1);
		expect_write(8, $signed(v2) >>> sh2);
		expect_write(14, v_min);
		expect_write(9, v2);
		expect_write(10, v1);
		expect_write(11, 16'd0);
		expect_write(15, v_min - 16'd1);
	endtask

	initial begin
		wb_trace_t got;
		seed = 32'h83ad;
		clk = 1'b0;
		arst_n = 1'b0;
		imem_data = '0;
		build_program();
		if (prog.size() > PROG_WORDS) begin
			report_failure("Program does not fit the 32-word table");
		end
		// Reset held 8 cycles with idle outputs
		for (int i = 0; i < 8; i++) begin
			@(posedge clk);
			#2;
			check_word(pc, '0, "pc in reset");
			check_word(imem_addr, '0, "imem_addr in reset");
			check_word(word_t'(hlt), '0, "hlt in reset");
			check_word(word_t'(wb_trace.valid), '0, "trace valid in reset");
		end
		arst_n = 1'b1;
		// Trace against expected table
		for (int i = 0; i < exp_writes.size(); i++) begin
			wait_for_trace(got);
			check_trace(got, exp_writes[i], i);
		end
		wait_for_halt();
		// Frozen PC and no writes
		repeat (20) begin
			@(negedge clk);
			check_word(pc, exp_final_pc, "pc after halt");
			check_word(imem_addr, exp_final_pc, "imem_addr after halt");
			check_word(word_t'(hlt), 16'd1, "hlt after halt");
			check_word(word_t'(wb_trace.valid), '0, "trace valid after halt");
		end
		$display("=== PASS ===");
		$finish;
	end

endmodule

`default_nettype wire

// File: vlog.f
hw/cpu_isa_pkg.sv
hw/cpu_pipe_pkg.sv
hw/register_file.sv
hw/fetch_stage.sv
hw/decode_stage.sv
hw/execute_stage.sv
hw/memory_stage.sv
hw/writeback_stage.sv
hw/cpu.sv
tb/cpu_tb.sv
